// File: logic/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

    // Command byte, first byte of every SPI transaction
    typedef enum logic [7:0] {
        op_write = 8'h01,                // Later bytes are stored to RAM
        op_read  = 8'h02                 // Later bytes return RAM contents
    } spi_op_t;                          // Other codes are ignored by the decoder

    // Byte bus request from the decoder to the RAM
    typedef struct packed {
        logic        strobe;             // One sys_clk cycle per access
        logic        we;                 // High for write, low for read
        logic [15:0] addr;               // Byte address, RAM uses low bits
        logic [7:0]  wdata;              // Write data, don't care on reads
    } bus_req_t;

    // RAM depth is 2**addr_width bytes
    localparam int default_addr_width = 10;

endpackage

`default_nettype wire

// File: logic/pe_pulse.sv
`timescale 1ns/1ps
`default_nettype none

module pe_pulse (
    input  wire  reset,                  // Async clear, active high
    input  wire  clk,                    // Destination clock
    input  wire  din,                    // Level from another clock domain
    output logic dout                    // One clk pulse per rising edge of din
);

    logic [1:0] sync;                    // Two-flop synchronizer chain
    logic       prev;                    // Synchronized level one cycle ago

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync <= 2'b00;
            prev <= 1'b0;
        end else begin
            sync <= {sync[0], din};      // Shift in the async level
            prev <= sync[1];             // Remember for edge detect
        end
    end

    // High only in the first cycle the synchronized level is seen high
    assign dout = sync[1] & ~prev;

endmodule

`default_nettype wire

// File: logic/spi_byte.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte (
    input  wire        sys_clk,          // System clock for the valid pulse
    input  wire        spi_cs_n,         // Chip select, also async reset
    input  wire        spi_sclk,         // Mode 0, low when spi_cs_n falls
    input  wire        spi_rx,           // Controller to peripheral data
    inout  wire        spi_tx,           // Released while spi_cs_n is high
    output logic [7:0] rx,               // Last received byte
    input  wire  [7:0] tx,               // Next byte to send, held by producer
    output logic       valid             // sys_clk pulse when rx is complete
);

    logic [2:0] bit_index;               // Bit position, MSB first
    logic       done;                    // High for one sclk period after bit 0
    logic       tx_preload;              // Set until the first falling edge
    logic       tx_bit;                  // Bit currently on the wire

    // Receive side sampled on rising sclk
    always_ff @(posedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            done      <= 1'b0;
            bit_index <= 3'd7;           // Start of a byte
        end else begin
            done      <= (bit_index == 3'd0);   // Last bit of the byte
            bit_index <= bit_index - 3'd1;      // Wraps to 7 for next byte
        end
    end

    // Receive shift register
    always_ff @(posedge spi_sclk) begin
        rx <= {rx[6:0], spi_rx};         // MSB arrives first
    end

    // Move done into the sys_clk domain
    pe_pulse valid_pulse_i (
        .reset (spi_cs_n),
        .clk   (sys_clk),
        .din   (done),
        .dout  (valid)
    );

    // Transmit side updated on falling sclk
    always_ff @(negedge spi_sclk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            tx_preload <= 1'b1;          // Bit 7 shown straight from tx
            tx_bit     <= 1'b0;
        end else begin
            tx_preload <= 1'b0;
            tx_bit     <= tx[bit_index]; // Index already points at next bit
        end
    end

    // Tri-state pin driver
    assign spi_tx = spi_cs_n   ? 1'bz :
                    tx_preload ? tx[7] :
                                 tx_bit;

endmodule

`default_nettype wire

// File: logic/spi_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd (
    input  wire                        sys_clk,   // System clock
    input  wire                        spi_cs_n,  // Async reset, ends a transaction
    input  wire  [7:0]                 rx,        // Received byte
    input  wire                        valid,     // One pulse per received byte
    output logic [7:0]                 tx,        // Byte for the next SPI slot
    output spi_bridge_pkg::bus_req_t   req,       // RAM request, registered
    input  wire  [7:0]                 rdata      // RAM read data
);

    // Transaction phase
    typedef enum logic [2:0] {
        cmd,                             // Waiting for the command byte
        addr_hi,                         // Waiting for addr[15:8]
        addr_lo,                         // Waiting for addr[7:0]
        data,                            // Streaming bytes to or from RAM
        ignore                           // Unknown command, idle until cs high
    } state_t;

    state_t                  state;
    spi_bridge_pkg::spi_op_t op_q;       // Latched command
    logic [15:0]             addr_q;     // Current byte address
    logic                    rd_pend;    // Read data arrives this cycle
    logic [15:0]             start_addr; // Full address when low byte arrives
    logic                    known_op;   // Command byte is write or read
    logic                    is_read;    // Latched command is a read

    assign start_addr = {addr_q[15:8], rx};
    assign known_op   = (rx == spi_bridge_pkg::op_write) ||
                        (rx == spi_bridge_pkg::op_read);
    assign is_read    = (op_q == spi_bridge_pkg::op_read);

    always_ff @(posedge sys_clk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            state   <= cmd;
            op_q    <= spi_bridge_pkg::op_write;
            addr_q  <= 16'h0000;
            rd_pend <= 1'b0;
            req     <= '0;
            tx      <= 8'h00;            // Nothing to send yet
        end else begin
            req.strobe <= 1'b0;          // Strobe lasts one cycle
            rd_pend    <= req.strobe & ~req.we;

            // Read result goes straight to the transmit byte
            if (rd_pend) begin
                tx <= rdata;
            end

            if (valid) begin
                case (state)
                    cmd: begin
                        if (known_op) begin
                            op_q  <= spi_bridge_pkg::spi_op_t'(rx);
                            state <= addr_hi;
                        end else begin
                            state <= ignore;     // tx stays 8'h00
                        end
                    end

                    addr_hi: begin
                        addr_q[15:8] <= rx;
                        state        <= addr_lo;
                    end

                    addr_lo: begin
                        state <= data;
                        if (is_read) begin
                            // Fetch first byte now so it is ready for byte 3
                            req <= '{strobe: 1'b1,
                                     we:     1'b0,
                                     addr:   start_addr,
                                     wdata:  8'h00};
                            addr_q <= start_addr + 16'd1;
                        end else begin
                            addr_q <= start_addr;    // First write target
                        end
                    end

                    data: begin
                        // Write stores rx, read prefetches the next byte
                        req <= '{strobe: 1'b1,
                                 we:     !is_read,
                                 addr:   addr_q,
                                 wdata:  rx};
                        addr_q <= addr_q + 16'd1;    // Auto increment
                    end

                    ignore: begin
                        state <= ignore;             // Wait for spi_cs_n
                    end

                    default: begin
                        state <= ignore;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/bus_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bus_ram #(
    parameter int addr_width = spi_bridge_pkg::default_addr_width  // At most 16
) (
    input  wire                        sys_clk,   // System clock
    input  wire spi_bridge_pkg::bus_req_t req,    // Request from the decoder
    output logic [7:0]                 rdata      // Valid one cycle after a read
);

    localparam int depth = 2 ** addr_width;      // Bytes in the array

    logic [7:0]            mem [depth];          // Contents kept across resets
    logic [addr_width-1:0] index;                // Wrapped byte address

    // Upper address bits are dropped so accesses wrap
    assign index = req.addr[addr_width-1:0];

    always_ff @(posedge sys_clk) begin
        if (req.strobe) begin
            if (req.we) begin
                mem[index] <= req.wdata;         // Byte write
            end else begin
                rdata <= mem[index];             // Registered read
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/spi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge #(
    parameter int addr_width = spi_bridge_pkg::default_addr_width  // RAM size 2**addr_width
) (
    input  wire sys_clk,                 // At least 16x spi_sclk
    input  wire spi_cs_n,                // Active low select, async reset when high
    input  wire spi_sclk,                // SPI clock, mode 0
    input  wire spi_rx,                  // Data from controller
    inout  wire spi_tx                   // Data to controller, high-Z when idle
);

    logic [7:0]               rx_byte;   // Byte from the shifter
    logic [7:0]               tx_byte;   // Byte for the shifter
    logic                     rx_valid;  // sys_clk pulse per received byte
    spi_bridge_pkg::bus_req_t bus_req;   // Decoder to RAM
    logic [7:0]               bus_rdata; // RAM to decoder

    // SPI pins to bytes
    spi_byte spi_byte_i (
        .sys_clk  (sys_clk),
        .spi_cs_n (spi_cs_n),
        .spi_sclk (spi_sclk),
        .spi_rx   (spi_rx),
        .spi_tx   (spi_tx),
        .rx       (rx_byte),
        .tx       (tx_byte),
        .valid    (rx_valid)
    );

    // Command, address and data sequencing
    spi_cmd spi_cmd_i (
        .sys_clk  (sys_clk),
        .spi_cs_n (spi_cs_n),
        .rx       (rx_byte),
        .valid    (rx_valid),
        .tx       (tx_byte),
        .req      (bus_req),
        .rdata    (bus_rdata)
    );

    // Backing store
    bus_ram #(
        .addr_width (addr_width)
    ) bus_ram_i (
        .sys_clk  (sys_clk),
        .req      (bus_req),
        .rdata    (bus_rdata)
    );

endmodule

`default_nettype wire

// File: tb/spi_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_tb;

    localparam int addr_width  = 10;             // RAM of 1024 bytes
    localparam int half_period = 8;              // sys_clk cycles per spi_sclk half
    localparam int max_cycles  = 100000;         // Watchdog limit in sys_clk cycles

    logic sys_clk;
    logic spi_cs_n;
    logic spi_rx;
    logic spi_sclk;
    wire  spi_tx;                                // Pulled high when released

    logic [7:0]  ref_mem [1 << addr_width];      // Mirror of completed writes
    logic [7:0]  wr_buf [16];                    // Bytes for the next write burst
    logic [7:0]  rd_buf [16];                    // Bytes seen in the last read burst
    logic [31:0] lfsr_state = 32'h1fd6;          // Random source
    int          value_errors   = 0;             // Wrong bytes on spi_tx
    int          other_errors   = 0;             // Protocol problems
    int          release_errors = 0;             // Bus not released while idle
    int          checks         = 0;
    logic        timed_out      = 1'b0;

    pullup (spi_tx);

    spi_bridge #(
        .addr_width (addr_width)
    ) spi_bridge_i (
        .sys_clk  (sys_clk),
        .spi_cs_n (spi_cs_n),
        .spi_sclk (spi_sclk),
        .spi_rx   (spi_rx),
        .spi_tx   (spi_tx)
    );

    // 4 ns system clock
    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int nbits, output logic [15:0] value);
        int i;
        value = 16'h0000;
        for (i = 0; i < nbits; i++) begin
            value      = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic rand_byte(output logic [7:0] value);
        logic [15:0] r;
        rand_bits(8, r);
        value = r[7:0];
    endtask

    // Drives land 1 ns after the rising edge
    task automatic wait_cycles(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge sys_clk);
        end
        #1;
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        assert (got == exp) else begin
            $display("FAILED %s: expected 0x%02h, observed 0x%02h", name, exp, got);
            value_errors++;
        end
    endtask

    // Mode 0 bit exchange MSB first
    // nbits below 8 cuts the byte short
    task automatic spi_xfer(input logic [7:0] mosi, input int nbits, output logic [7:0] miso);
        int i;
        miso = 8'h00;
        for (i = 7; i >= 8 - nbits; i--) begin
            spi_rx = mosi[i];                    // Set up while sclk is low
            wait_cycles(half_period);
            miso[i]  = spi_tx;                   // Sample before the rising edge
            spi_sclk = 1'b1;
            wait_cycles(half_period);
            spi_sclk = 1'b0;                     // DUT shifts out next bit here
        end
    endtask

    // Select and expect the DUT to take the pin within a few cycles
    task automatic cs_begin();
        int n;
        wait_cycles(1);
        spi_cs_n = 1'b0;
        for (n = 0; n < 4 && spi_tx != 1'b0; n++) begin
            wait_cycles(1);
        end
        checks++;
        assert (spi_tx == 1'b0) else begin
            $display("FAILED spi_tx after select: expected 0x0, observed 0x%01h", spi_tx);
            other_errors++;
        end
    endtask

    // Leave room for the last write before deselect
    task automatic cs_end();
        wait_cycles(half_period);
        spi_cs_n = 1'b1;
        spi_rx   = 1'b0;
        wait_cycles(2 * half_period);
    endtask

    // Command and two address bytes all answered with 8'h00
    task automatic send_header(input logic [7:0] op, input logic [15:0] addr);
        logic [7:0] miso;
        spi_xfer(op, 8, miso);
        check_byte("spi_tx command byte", 8'h00, miso);
        spi_xfer(addr[15:8], 8, miso);
        check_byte("spi_tx addr_hi byte", 8'h00, miso);
        spi_xfer(addr[7:0], 8, miso);
        check_byte("spi_tx addr_lo byte", 8'h00, miso);
    endtask

    task automatic write_burst(input logic [15:0] addr, input int n);
        logic [7:0] miso;
        logic [9:0] idx;
        int         i;
        cs_begin();
        send_header(spi_bridge_pkg::op_write, addr);
        for (i = 0; i < n; i++) begin
            spi_xfer(wr_buf[i], 8, miso);
        end
        cs_end();
        for (i = 0; i < n; i++) begin
            idx          = addr[9:0] + 10'(i);   // Wraps like the RAM
            ref_mem[idx] = wr_buf[i];
        end
    endtask

    // Byte 3 onward must carry the mirrored contents
    task automatic read_burst(input logic [15:0] addr, input int n);
        logic [7:0] miso;
        logic [9:0] idx;
        int         i;
        cs_begin();
        send_header(spi_bridge_pkg::op_read, addr);
        for (i = 0; i < n; i++) begin
            spi_xfer(8'hff, 8, miso);
            idx       = addr[9:0] + 10'(i);
            rd_buf[i] = miso;
            check_byte("spi_tx read data", ref_mem[idx], miso);
        end
        cs_end();
    endtask

    task automatic fill_wr_buf(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            rand_byte(wr_buf[i]);
        end
    endtask

    // Unknown command returns zero on every byte
    task automatic ignored_transaction(input logic [15:0] addr, input int n);
        logic [7:0] miso;
        logic [7:0] junk;
        int         i;
        cs_begin();
        send_header(8'h7e, addr);
        for (i = 0; i < n; i++) begin
            rand_byte(junk);
            spi_xfer(junk, 8, miso);
            check_byte("spi_tx ignored command", 8'h00, miso);
        end
        cs_end();
    endtask

    // Deselect after the header and again inside the data byte
    task automatic aborted_write(input logic [15:0] addr);
        logic [7:0] miso;
        cs_begin();
        send_header(spi_bridge_pkg::op_write, addr);
        cs_end();
        cs_begin();
        send_header(spi_bridge_pkg::op_write, addr);
        spi_xfer(~ref_mem[addr[9:0]], 5, miso);
        cs_end();
    endtask

    task automatic report_and_finish();
        int total;
        total = value_errors + other_errors + release_errors + (timed_out ? 1 : 0);
        $display("Checks %0d, value errors %0d, protocol errors %0d, release errors %0d",
                 checks, value_errors, other_errors + (timed_out ? 1 : 0), release_errors);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // Released pin floats to the pull-up level
    always @(posedge sys_clk) begin
        if (spi_cs_n) begin
            assert (spi_tx == 1'b1) else begin
                $display("FAILED spi_tx released: expected 0x1, observed 0x%01h", spi_tx);
                release_errors++;
            end
        end
    end

    // Watchdog on the whole sequence
    initial begin
        int cyc;
        for (cyc = 0; cyc < max_cycles; cyc++) begin
            @(posedge sys_clk);
        end
        $display("Timeout: the test sequence did not finish in %0d sys_clk cycles", max_cycles);
        timed_out = 1'b1;
        report_and_finish();
    end

    initial begin
        logic [15:0] addr;
        logic [15:0] burst_addr;
        int          k;
        spi_cs_n = 1'b1;                         // Held in reset
        spi_sclk = 1'b0;
        spi_rx   = 1'b0;
        wait_cycles(8);

        // Single byte write then read back at random spots
        for (k = 0; k < 4; k++) begin
            rand_bits(16, addr);
            fill_wr_buf(1);
            write_burst(addr, 1);
            read_burst(addr, 1);
        end

        // Auto-increment bursts
        rand_bits(16, burst_addr);
        fill_wr_buf(8);
        write_burst(burst_addr, 8);
        read_burst(burst_addr, 8);

        // Burst across the top of the RAM
        fill_wr_buf(6);
        write_burst(16'h03fe, 6);
        read_burst(16'h0000, 2);
        check_byte("spi_tx wrap addr 0", wr_buf[2], rd_buf[0]);
        check_byte("spi_tx wrap addr 1", wr_buf[3], rd_buf[1]);
        read_burst(16'h03fe, 6);

        // Unknown command aimed at the burst leaves it intact
        ignored_transaction(burst_addr, 6);
        read_burst(burst_addr, 8);

        // Cut off writes leave the old byte in place
        rand_bits(16, addr);
        fill_wr_buf(1);
        write_burst(addr, 1);
        aborted_write(addr);
        read_burst(addr, 1);

        report_and_finish();
    end

endmodule

`default_nettype wire

// File: spi_bridge.f
logic/spi_bridge_pkg.sv
logic/pe_pulse.sv
logic/spi_byte.sv
logic/spi_cmd.sv
logic/bus_ram.sv
logic/spi_bridge.sv
tb/spi_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SPI bridge testbench with Verilator, result from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f spi_bridge.f \
    --top-module spi_bridge_tb \
    -o spi_bridge_sim \
    && ./obj_dir/spi_bridge_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log \
    && { echo "Result: FAIL"; exit 1; } \
    || { echo "Result: PASS"; exit 0; }
